//--- build.f
+incdir+include
hdl/decode_pkg.sv
hdl/op_decoder.sv
hdl/operand_builder.sv
hdl/reg_lock_queue.sv
hdl/decode_stage.sv
sim/tb_clock.sv
sim/decode_asserts.sv
sim/decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module decode_tb -f build.f -o decode_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "Simulation ended without a pass result"
    exit 1
fi
exit 0

//--- sim/decode_tb.sv
// Decode stage testbench

`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module decode_tb;

    localparam int NUM_CYCLES = 5000;

    logic                   clk;
    logic                   reset;
    logic                   stall_i;
    logic [`XLEN-1:0]       instruction_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`XLEN-1:0]       rs1_data_i;
    logic [`XLEN-1:0]       rs2_data_i;
    logic [`REG_ADDR_W-1:0] rs1_o;
    logic [`REG_ADDR_W-1:0] rs2_o;
    logic [`REG_ADDR_W-1:0] rd_o;
    logic [`XLEN-1:0]       first_operand_o;
    logic [`XLEN-1:0]       second_operand_o;
    logic [`XLEN-1:0]       third_operand_o;
    logic [`XLEN-1:0]       pc_o;
    decode_pkg::op_e        op_o;
    logic                   hazard_o;
    logic                   exception_o;

    logic [31:0]            lfsr_state = 32'he01d_3da3;
    logic [`XLEN-1:0]       bank [32];          // Register bank contents
    int                     error_count = 0;
    logic                   hold = 1'b0;        // Producer keeps the word

    // Model lock queue and expected registered outputs
    logic [`REG_ADDR_W-1:0] m_rd0 = '0;
    logic [`REG_ADDR_W-1:0] m_rd1 = '0;
    logic                   m_st0 = 1'b0;
    logic                   m_st1 = 1'b0;
    decode_pkg::op_e        exp_op = decode_pkg::NOP;
    logic                   exp_exc = 1'b0;
    logic [`XLEN-1:0]       exp_first = '0;
    logic [`XLEN-1:0]       exp_second = '0;
    logic [`XLEN-1:0]       exp_third = '0;
    logic [`XLEN-1:0]       exp_pc = '0;
    logic [`REG_ADDR_W-1:0] exp_rd = '0;

    tb_clock u_tb_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    decode_stage uut (.*);

    bind decode_stage decode_asserts u_decode_asserts (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .hazard_i    (hazard_o),
        .op_i        (op_o),
        .exception_i (exception_o),
        .first_i     (first_operand_o),
        .second_i    (second_operand_o),
        .third_i     (third_operand_o),
        .pc_i        (pc_o),
        .rd_i        (rd_o)
    );

    ////////////////////////////////////////////////////////////
    // Random source with taps 32 22 2 1
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Only x0..x15 so that matches with the lock slots come often
    function automatic logic [4:0] random_reg();
        logic [31:0] b;
        b = take_bits(4);
        return {1'b0, b[3:0]};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] pick;
        logic [31:0] b;
        logic [6:0]  opcode;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        pick = take_bits(4);
        if (pick < 32'd2) return take_bits(32);     // Raw word that is mostly invalid
        case (pick[3:0])
            4'd2:    opcode = `OPC_LUI;
            4'd3:    opcode = `OPC_AUIPC;
            4'd4:    opcode = `OPC_JAL;
            4'd5:    opcode = `OPC_JALR;
            4'd6:    opcode = `OPC_BRANCH;
            4'd7:    opcode = `OPC_LOAD;
            4'd8:    opcode = `OPC_LOAD;
            4'd9:    opcode = `OPC_STORE;
            4'd10:   opcode = `OPC_STORE;
            4'd11:   opcode = `OPC_OP_IMM;
            4'd12:   opcode = `OPC_OP_IMM;
            4'd13:   opcode = `OPC_OP;
            4'd14:   opcode = `OPC_OP;
            default: opcode = 7'b1110011;           // SYSTEM decodes as invalid
        endcase
        b = take_bits(3);
        f3 = b[2:0];
        b = take_bits(2);
        case (b[1:0])
            2'd1:    f7 = 7'b0100000;               // SUB, SRA
            2'd3: begin
                b = take_bits(7);
                f7 = b[6:0];                        // Odd funct7 that can set the sign bit
            end
            default: f7 = 7'b0000000;
        endcase
        rd  = random_reg();
        rs1 = random_reg();
        rs2 = random_reg();
        return {f7, rs2, rs1, f3, rd, opcode};
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic decode_pkg::op_e model_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            `OPC_LUI:   return decode_pkg::LUI;
            `OPC_AUIPC: return decode_pkg::ADD;
            `OPC_JAL:   return decode_pkg::JAL;
            `OPC_JALR:  return decode_pkg::JALR;
            `OPC_BRANCH: begin
                case (f3)
                    3'd0:    return decode_pkg::BEQ;
                    3'd1:    return decode_pkg::BNE;
                    3'd4:    return decode_pkg::BLT;
                    3'd5:    return decode_pkg::BGE;
                    3'd6:    return decode_pkg::BLTU;
                    3'd7:    return decode_pkg::BGEU;
                    default: return decode_pkg::INVALID;
                endcase
            end
            `OPC_LOAD: begin
                case (f3)
                    3'd0:    return decode_pkg::LB;
                    3'd1:    return decode_pkg::LH;
                    3'd2:    return decode_pkg::LW;
                    3'd4:    return decode_pkg::LBU;
                    3'd5:    return decode_pkg::LHU;
                    default: return decode_pkg::INVALID;
                endcase
            end
            `OPC_STORE: begin
                case (f3)
                    3'd0:    return decode_pkg::SB;
                    3'd1:    return decode_pkg::SH;
                    3'd2:    return decode_pkg::SW;
                    default: return decode_pkg::INVALID;
                endcase
            end
            `OPC_OP_IMM: begin
                case (f3)
                    3'd0: return decode_pkg::ADD;
                    3'd2: return decode_pkg::SLT;
                    3'd3: return decode_pkg::SLTU;
                    3'd4: return decode_pkg::XOR;
                    3'd6: return decode_pkg::OR;
                    3'd7: return decode_pkg::AND;
                    3'd1: return (f7 == 7'h00) ? decode_pkg::SLL : decode_pkg::INVALID;
                    default: begin                  // Right shifts
                        if (f7 == 7'h00) return decode_pkg::SRL;
                        if (f7 == 7'h20) return decode_pkg::SRA;
                        return decode_pkg::INVALID;
                    end
                endcase
            end
            `OPC_OP: begin
                case ({f7, f3})
                    10'h000: return decode_pkg::ADD;
                    10'h001: return decode_pkg::SLL;
                    10'h002: return decode_pkg::SLT;
                    10'h003: return decode_pkg::SLTU;
                    10'h004: return decode_pkg::XOR;
                    10'h005: return decode_pkg::SRL;
                    10'h006: return decode_pkg::OR;
                    10'h007: return decode_pkg::AND;
                    10'h100: return decode_pkg::SUB;
                    10'h105: return decode_pkg::SRA;
                    default: return decode_pkg::INVALID;
                endcase
            end
            default: return decode_pkg::INVALID;    // SYSTEM, FENCE, junk
        endcase
    endfunction

    task automatic model_operands(input logic [31:0] w, input logic [31:0] pc,
                                  input logic [31:0] r1, input logic [31:0] r2,
                                  output logic [31:0] f, output logic [31:0] s,
                                  output logic [31:0] t);
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (w[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                f = pc;
                s = imm_u;
                t = imm_u;
            end
            `OPC_JAL: begin
                f = pc;
                s = imm_j;
                t = imm_j;
            end
            `OPC_BRANCH: begin
                f = r1;
                s = r2;
                t = imm_b;
            end
            `OPC_STORE: begin
                f = r1;
                s = imm_s;
                t = r2;                             // Store data last
            end
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: begin
                f = r1;
                s = imm_i;
                t = imm_i;
            end
            default: begin                          // OP and invalid words carry no immediate
                f = r1;
                s = r2;
                t = '0;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string what);
        error_count++;
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                    $time, name, got, want));
        end
    endtask

    task automatic check_outputs();
        check_value("op_o", 32'(op_o), 32'(exp_op));
        check_value("exception_o", 32'(exception_o), 32'(exp_exc));
        check_value("first_operand_o", first_operand_o, exp_first);
        check_value("second_operand_o", second_operand_o, exp_second);
        check_value("third_operand_o", third_operand_o, exp_third);
        check_value("pc_o", pc_o, exp_pc);
        check_value("rd_o", 32'(rd_o), 32'(exp_rd));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) stop_on_error("reset was still high after 20 cycles");
        end while (reset);
    endtask

    // One cycle of stimulus driven at a falling edge
    task automatic drive_cycle();
        logic [31:0]            b;
        logic [4:0]             ra;
        logic [4:0]             rb;
        logic                   hz;
        logic                   is_load;
        if (!hold) begin
            instruction_i = random_instr();
            b = take_bits(30);
            pc_i = {b[29:0], 2'b00};
        end
        b = take_bits(4);
        stall_i = (b < 32'd2);                      // About one cycle in eight
        #1;                                         // Let rs1_o and rs2_o settle
        ra = instruction_i[19:15];
        rb = instruction_i[24:20];
        check_value("rs1_o", 32'(rs1_o), 32'(ra));
        check_value("rs2_o", 32'(rs2_o), 32'(rb));
        rs1_data_i = bank[rs1_o];                   // Same-cycle bank read
        rs2_data_i = bank[rs2_o];
        is_load = (instruction_i[6:0] == `OPC_LOAD);
        hz = ((ra != 5'd0) && (ra == m_rd0)) || ((rb != 5'd0) && (rb == m_rd0))
             || (is_load && (m_st0 || m_st1));
        check_value("hazard_o", 32'(hazard_o), 32'(hz));
        if (!stall_i) begin
            if (hz) begin
                exp_op     = decode_pkg::NOP;       // Bubble
                exp_exc    = 1'b0;
                exp_first  = '0;
                exp_second = '0;
                exp_third  = '0;
                exp_pc     = '0;
            end else begin
                exp_op  = model_op(instruction_i);
                exp_exc = (exp_op == decode_pkg::INVALID);
                model_operands(instruction_i, pc_i, bank[ra], bank[rb],
                               exp_first, exp_second, exp_third);
                exp_pc  = pc_i;
            end
            m_rd1  = m_rd0;                         // Queue shift
            m_st1  = m_st0;
            m_rd0  = hz ? 5'd0 : instruction_i[11:7];
            m_st0  = !hz && (instruction_i[6:0] == `OPC_STORE);
            exp_rd = m_rd1;
        end
        hold = hz || stall_i;                       // Producer keeps word and PC
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        int cycle;
        stall_i       = 1'b0;
        instruction_i = '0;
        pc_i          = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        for (i = 0; i < 32; i++) begin
            bank[i] = take_bits(32);
        end
        wait_reset_release();
        for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            check_outputs();                        // First pass sees reset values
            drive_cycle();
            @(negedge clk);
        end
        check_outputs();
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "errors were found");
        end
    end

endmodule

`default_nettype wire

//--- sim/decode_asserts.sv
// Decode stage bound assertions

`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module decode_asserts (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   stall_i,
    input  wire logic                   hazard_i,
    input  wire decode_pkg::op_e        op_i,
    input  wire logic                   exception_i,
    input  wire logic [`XLEN-1:0]       first_i,
    input  wire logic [`XLEN-1:0]       second_i,
    input  wire logic [`XLEN-1:0]       third_i,
    input  wire logic [`XLEN-1:0]       pc_i,
    input  wire logic [`REG_ADDR_W-1:0] rd_i
);

    // Hazard edge loads a bubble
    bubble_after_hazard: assert property (@(posedge clk) disable iff (reset)
        (hazard_i && !stall_i) |=> (op_i == decode_pkg::NOP))
        else $error("hazard edge did not load a NOP bubble");

    // Stalled edge leaves the output register and writeback address alone
    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall_i |=> ($stable(op_i) && $stable(exception_i) && $stable(first_i)
                     && $stable(second_i) && $stable(third_i) && $stable(pc_i)
                     && $stable(rd_i)))
        else $error("registered outputs changed across a stalled edge");

    no_exception_on_nop: assert property (@(posedge clk) disable iff (reset)
        !(exception_i && (op_i == decode_pkg::NOP)))
        else $error("exception flag raised together with a NOP");

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// Testbench clock and reset

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;      // 4 ns period
    end

    // High for two rising edges, dropped right after the second
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
// RV32I decode stage

`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module decode_stage (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   stall_i,            // Hold outputs and queue
    input  wire logic [`XLEN-1:0]       instruction_i,
    input  wire logic [`XLEN-1:0]       pc_i,
    input  wire logic [`XLEN-1:0]       rs1_data_i,         // Same-cycle bank read
    input  wire logic [`XLEN-1:0]       rs2_data_i,
    output logic [`REG_ADDR_W-1:0]      rs1_o,              // Bank read addresses
    output logic [`REG_ADDR_W-1:0]      rs2_o,
    output logic [`REG_ADDR_W-1:0]      rd_o,               // Bank write address
    output logic [`XLEN-1:0]            first_operand_o,
    output logic [`XLEN-1:0]            second_operand_o,
    output logic [`XLEN-1:0]            third_operand_o,
    output logic [`XLEN-1:0]            pc_o,
    output decode_pkg::op_e             op_o,
    output logic                        hazard_o,
    output logic                        exception_o         // Invalid encoding
);

    decode_pkg::op_e        op;
    decode_pkg::format_e    fmt;
    logic                   is_load;
    logic                   is_store;
    logic [`XLEN-1:0]       first_operand;
    logic [`XLEN-1:0]       second_operand;
    logic [`XLEN-1:0]       third_operand;
    logic [`REG_ADDR_W-1:0] rd_field;

    // Register fields straight from the word
    assign rs1_o    = instruction_i[19:15];
    assign rs2_o    = instruction_i[24:20];
    assign rd_field = instruction_i[11:7];

    ////////////////////////////////////////////////////////////
    // Decode, operands, locks
    ////////////////////////////////////////////////////////////

    op_decoder u_op_decoder (
        .instr_i    (instruction_i),
        .op_o       (op),
        .format_o   (fmt),
        .is_load_o  (is_load),
        .is_store_o (is_store)
    );

    operand_builder u_operand_builder (
        .instr_i    (instruction_i),
        .format_i   (fmt),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .first_o    (first_operand),
        .second_o   (second_operand),
        .third_o    (third_operand)
    );

    reg_lock_queue u_reg_lock_queue (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .rs1_i      (rs1_o),
        .rs2_i      (rs2_o),
        .rd_i       (rd_field),
        .is_load_i  (is_load),
        .is_store_i (is_store),
        .hazard_o   (hazard_o),
        .rd_o       (rd_o)
    );

    ////////////////////////////////////////////////////////////
    // Output register, reset > stall > bubble > accept
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || (!stall_i && hazard_o)) begin
            first_operand_o  <= '0;             // Reset and bubble look the same
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            op_o             <= decode_pkg::NOP;
            exception_o      <= 1'b0;
        end else if (!stall_i) begin
            first_operand_o  <= first_operand;
            second_operand_o <= second_operand;
            third_operand_o  <= third_operand;
            pc_o             <= pc_i;
            op_o             <= op;
            exception_o      <= (op == decode_pkg::INVALID);
        end
        // Stall keeps everything
    end

endmodule

`default_nettype wire

//--- hdl/reg_lock_queue.sv
// Register and store lock queue

`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module reg_lock_queue (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       stall_i,        // Freeze both slots
    input  wire logic [`REG_ADDR_W-1:0]     rs1_i,
    input  wire logic [`REG_ADDR_W-1:0]     rs2_i,
    input  wire logic [`REG_ADDR_W-1:0]     rd_i,           // Current rd field
    input  wire logic                       is_load_i,
    input  wire logic                       is_store_i,
    output logic                            hazard_o,       // Issue a bubble
    output logic [`REG_ADDR_W-1:0]          rd_o            // Writeback address
);

    // Slot 0 is the instruction just accepted, slot 1 the one before
    logic [`REG_ADDR_W-1:0] lock_rd [2];
    logic                   lock_st [2];    // Slot holds a store

    logic                   src_hazard;
    logic                   mem_hazard;
    logic [`REG_ADDR_W-1:0] next_rd;
    logic                   next_st;

    ////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////

    // Only the newest lock is checked, x0 never locks
    assign src_hazard = ((rs1_i != '0) && (rs1_i == lock_rd[0]))
                     || ((rs2_i != '0) && (rs2_i == lock_rd[0]));

    // Load waits for every store still in flight
    assign mem_hazard = is_load_i && (lock_st[0] || lock_st[1]);

    assign hazard_o = src_hazard || mem_hazard;

    // A bubble enqueues an empty slot
    assign next_rd = hazard_o ? '0 : rd_i;
    assign next_st = hazard_o ? 1'b0 : is_store_i;

    ////////////////////////////////////////////////////////////
    // Shift on every non-stalled edge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_rd[0] <= '0;
            lock_rd[1] <= '0;
            lock_st[0] <= 1'b0;
            lock_st[1] <= 1'b0;
        end else if (!stall_i) begin
            lock_rd[0] <= next_rd;
            lock_st[0] <= next_st;
            lock_rd[1] <= lock_rd[0];       // Older slot
            lock_st[1] <= lock_st[0];
        end
    end

    assign rd_o = lock_rd[1];   // Two accepted edges back

endmodule

`default_nettype wire

//--- hdl/operand_builder.sv
// Immediate and operand select

`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module operand_builder (
    input  wire logic [`XLEN-1:0]       instr_i,
    input  wire decode_pkg::format_e    format_i,
    input  wire logic [`XLEN-1:0]       pc_i,
    input  wire logic [`XLEN-1:0]       rs1_data_i,     // From register bank
    input  wire logic [`XLEN-1:0]       rs2_data_i,     // From register bank
    output logic [`XLEN-1:0]            first_o,
    output logic [`XLEN-1:0]            second_o,
    output logic [`XLEN-1:0]            third_o
);

    logic [`XLEN-1:0] imm;

    ////////////////////////////////////////////////////////////
    // Immediate extraction
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (format_i)
            decode_pkg::I_TYPE: imm = {{21{instr_i[31]}}, instr_i[30:20]};
            decode_pkg::S_TYPE: imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            decode_pkg::B_TYPE: begin
                // Bit 11 sits at instr[7], LSB always zero
                imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
            end
            decode_pkg::U_TYPE: imm = {instr_i[31:12], 12'b0};  // Upper 20 bits
            decode_pkg::J_TYPE: begin
                // Scrambled 20-bit offset, halfword aligned
                imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};
            end
            default:            imm = '0;                       // R_TYPE
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand select per format
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (format_i)
            decode_pkg::U_TYPE, decode_pkg::J_TYPE: begin
                first_o  = pc_i;        // AUIPC and JAL work off the PC
                second_o = imm;
                third_o  = imm;
            end
            decode_pkg::R_TYPE, decode_pkg::B_TYPE: begin
                first_o  = rs1_data_i;
                second_o = rs2_data_i;
                third_o  = imm;         // Branch offset, zero for R
            end
            decode_pkg::S_TYPE: begin
                first_o  = rs1_data_i;  // Base address
                second_o = imm;         // Offset
                third_o  = rs2_data_i;  // Store data
            end
            default: begin              // I_TYPE
                first_o  = rs1_data_i;
                second_o = imm;
                third_o  = imm;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/op_decoder.sv
// RV32I operation decoder

`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module op_decoder (
    input  wire logic [`XLEN-1:0]   instr_i,        // Raw instruction word
    output decode_pkg::op_e         op_o,           // Decoded operation
    output decode_pkg::format_e     format_o,       // Immediate format
    output logic                    is_load_o,      // LOAD major opcode
    output logic                    is_store_o      // STORE major opcode
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Per-class results, picked by the opcode below
    decode_pkg::op_e branch_op;
    decode_pkg::op_e load_op;
    decode_pkg::op_e store_op;
    decode_pkg::op_e op_imm_op;
    decode_pkg::op_e op_op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////////////////////////
    // Class tables
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  branch_op = decode_pkg::BEQ;
            3'b001:  branch_op = decode_pkg::BNE;
            3'b100:  branch_op = decode_pkg::BLT;
            3'b101:  branch_op = decode_pkg::BGE;
            3'b110:  branch_op = decode_pkg::BLTU;
            3'b111:  branch_op = decode_pkg::BGEU;
            default: branch_op = decode_pkg::INVALID;   // 010, 011 reserved
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  load_op = decode_pkg::LB;
            3'b001:  load_op = decode_pkg::LH;
            3'b010:  load_op = decode_pkg::LW;
            3'b100:  load_op = decode_pkg::LBU;
            3'b101:  load_op = decode_pkg::LHU;
            default: load_op = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  store_op = decode_pkg::SB;
            3'b001:  store_op = decode_pkg::SH;
            3'b010:  store_op = decode_pkg::SW;
            default: store_op = decode_pkg::INVALID;
        endcase
    end

    // OP-IMM, funct7 only matters for the shifts
    always_comb begin
        op_imm_op = decode_pkg::INVALID;
        case (funct3)
            3'b000: op_imm_op = decode_pkg::ADD;        // ADDI
            3'b010: op_imm_op = decode_pkg::SLT;        // SLTI
            3'b011: op_imm_op = decode_pkg::SLTU;       // SLTIU
            3'b100: op_imm_op = decode_pkg::XOR;        // XORI
            3'b110: op_imm_op = decode_pkg::OR;         // ORI
            3'b111: op_imm_op = decode_pkg::AND;        // ANDI
            3'b001: begin
                if (funct7 == 7'b0000000) op_imm_op = decode_pkg::SLL;
            end
            default: begin                              // 101, right shifts
                if (funct7 == 7'b0000000) op_imm_op = decode_pkg::SRL;
                else if (funct7 == 7'b0100000) op_imm_op = decode_pkg::SRA;
            end
        endcase
    end

    // OP, alternate funct7 only for SUB and SRA
    always_comb begin
        op_op = decode_pkg::INVALID;
        if (funct7 == 7'b0000000) begin
            case (funct3)
                3'b000:  op_op = decode_pkg::ADD;
                3'b001:  op_op = decode_pkg::SLL;
                3'b010:  op_op = decode_pkg::SLT;
                3'b011:  op_op = decode_pkg::SLTU;
                3'b100:  op_op = decode_pkg::XOR;
                3'b101:  op_op = decode_pkg::SRL;
                3'b110:  op_op = decode_pkg::OR;
                default: op_op = decode_pkg::AND;
            endcase
        end else if (funct7 == 7'b0100000) begin
            if (funct3 == 3'b000) op_op = decode_pkg::SUB;
            else if (funct3 == 3'b101) op_op = decode_pkg::SRA;
        end
    end

    ////////////////////////////////////////////////////////////
    // Major opcode select and format
    ////////////////////////////////////////////////////////////

    always_comb begin
        op_o     = decode_pkg::INVALID;     // SYSTEM, MISC-MEM and unknown
        format_o = decode_pkg::R_TYPE;
        case (opcode)
            `OPC_LUI:    begin op_o = decode_pkg::LUI;  format_o = decode_pkg::U_TYPE; end
            `OPC_AUIPC:  begin op_o = decode_pkg::ADD;  format_o = decode_pkg::U_TYPE; end
            `OPC_JAL:    begin op_o = decode_pkg::JAL;  format_o = decode_pkg::J_TYPE; end
            `OPC_JALR:   begin op_o = decode_pkg::JALR; format_o = decode_pkg::I_TYPE; end
            `OPC_BRANCH: begin op_o = branch_op;        format_o = decode_pkg::B_TYPE; end
            `OPC_LOAD:   begin op_o = load_op;          format_o = decode_pkg::I_TYPE; end
            `OPC_STORE:  begin op_o = store_op;         format_o = decode_pkg::S_TYPE; end
            `OPC_OP_IMM: begin op_o = op_imm_op;        format_o = decode_pkg::I_TYPE; end
            `OPC_OP:     op_o = op_op;                  // Stays R_TYPE
            default:     ;
        endcase
    end

    // Memory flags from the opcode alone, for the lock queue
    assign is_load_o  = (opcode == `OPC_LOAD);
    assign is_store_o = (opcode == `OPC_STORE);

endmodule

`default_nettype wire

//--- hdl/decode_pkg.sv
// Decode stage types

`default_nettype none

package decode_pkg;

    ////////////////////////////////////////////////////////////
    // Operation codes sent to execute
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,                        // Bubble, also reset value
        LUI,
        ADD,                        // ADD, ADDI and AUIPC
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        JAL,
        JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        INVALID                     // Raises exception_o
    } op_e;

    ////////////////////////////////////////////////////////////
    // Instruction formats, pick immediate and operands
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        R_TYPE,                     // No immediate
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

endpackage

`default_nettype wire

//--- include/decode_defines.svh
// Decode stage widths and opcodes

`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

////////////////////////////////////////////////////////////
// Widths fixed by the ISA
////////////////////////////////////////////////////////////

`define XLEN        32          // Data and PC width
`define REG_ADDR_W  5           // x0..x31

////////////////////////////////////////////////////////////
// RV32I major opcodes, instr[6:0]
////////////////////////////////////////////////////////////

`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011  // BEQ..BGEU
`define OPC_LOAD    7'b0000011  // LB..LHU
`define OPC_STORE   7'b0100011  // SB, SH, SW
`define OPC_OP_IMM  7'b0010011  // ALU with immediate
`define OPC_OP      7'b0110011  // ALU register-register

// SYSTEM and MISC-MEM are not listed
// They fall to the invalid path in the decoder

`endif
